/* bench/bd_encoder_assertions.sv */
`timescale 1ns/1ps

module bd_encoder_assertions
  import bd_link_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input logic                            clk,
  input logic                            arst_n,
  input logic [BD_W-1:0]                 bd_data,
  input logic                            bd_valid,
  input logic                            bd_ack,
  input logic                            in_ack,
  input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
  input logic                            enable,
  input logic                            psel,
  input logic                            penable,
  input logic                            pslverr
);

  // running total, read back by the testbench at the end
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // output channel

  // stalled word holds still until the ack
  stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bd_valid && !bd_ack |=> bd_valid && $stable(bd_data))
  else begin
    fail_count++;
    $error("bd_valid or bd_data moved while bd_ack was low");
  end

  // nothing leaves while disabled
  idle_when_off: assert property (@(posedge clk) disable iff (!arst_n)
    !enable |-> !bd_valid)
  else begin
    fail_count++;
    $error("bd_valid high while enable was low");
  end

  //////////////////////////////////////////////////////////////////////
  // host side and apb

  // full fifo refuses words
  full_no_ack: assert property (@(posedge clk) disable iff (!arst_n)
    fifo_count == FIFO_DEPTH |-> !in_ack)
  else begin
    fail_count++;
    $error("in_ack high with the FIFO full");
  end

  // slave error only in the access phase
  err_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> psel && penable)
  else begin
    fail_count++;
    $error("pslverr high outside an APB access phase");
  end

endmodule

/* bench/bd_encoder_tb.sv */
`timescale 1ns/1ps

module bd_encoder_tb
  import bd_link_pkg::*;
  import bd_leaf_pkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int CNT_W = 16;
  localparam int SEED = 23;
  localparam int RESET_CYCLES = 4;
  // invalid codes 34..63, each chased by one valid word
  localparam int N_BAD = 64 - N_LEAVES;
  localparam int N_STALL_WORDS = 48;
  localparam int N_WORDS = N_LEAVES + 2 * N_BAD + N_STALL_WORDS + FIFO_DEPTH;
  localparam int N_APB = 24;
  localparam int DRAIN_POLLS = 64;
  // 20 cycles a word, 4 cycles an apb access
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_WORDS * 20 + N_APB * 4;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic [CODE_W-1:0]     in_leaf;
  logic [PAYLOAD_W-1:0]  in_payload;
  logic                  in_valid;
  logic                  in_ack;
  logic [BD_W-1:0]       bd_data;
  logic                  bd_valid;
  logic                  bd_ack;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // model state
  logic [BD_W-1:0]       exp_q[$];
  logic [BD_W-1:0]       exp_word;
  logic [31:0]           stim_state;
  logic [31:0]           ack_state;
  logic [APB_DATA_W-1:0] rdata;
  logic                  stall_mode;
  logic                  saw_full;
  int                    sent_exp;
  int                    drop_exp;
  int                    checks;
  int                    errors;
  int                    fails;
  int                    i;

  bd_encoder_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) DUT (.*);

  bind bd_encoder_top bd_encoder_assertions #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_assert (
    .*,
    .fifo_count (u_fifo.count)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // low lcg bits are weak, hand out the upper ones
  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return {8'b0, stim_state[31:8]};
  endfunction

  // payload above the route, route in the low bits, cut to 21 bits
  function automatic logic [BD_W-1:0] encode_word(input logic [CODE_W-1:0] leaf,
                                                  input logic [PAYLOAD_W-1:0] payload);
    logic [31:0] wide;
    wide = (32'(payload) << LEAF_ROUTE_LEN[leaf]) | 32'(LEAF_ROUTE[leaf]);
    return wide[BD_W-1:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // in_ack only changes on rising edges, so the falling edge sees it settled
  task automatic push_word(input logic [CODE_W-1:0] leaf, input logic [PAYLOAD_W-1:0] payload);
    @(negedge clk);
    in_leaf = leaf;
    in_payload = payload;
    in_valid = 1'b1;
    while (!in_ack) begin
      saw_full = 1'b1;
      @(negedge clk);
    end
    if (leaf < N_LEAVES) begin
      exp_q.push_back(encode_word(leaf, payload));
      sent_exp++;
    end else begin
      drop_exp++;
    end
    @(posedge clk);
  endtask

  task automatic idle_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // setup phase, access phase, then back to idle
  task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata, input logic exp_err,
                            output logic [APB_DATA_W-1:0] data);
    logic err;
    logic rdy;
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    // zero wait states, the access completes on this edge
    @(posedge clk);
    data = prdata;
    err = pslverr;
    rdy = pready;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    check_value("pready", rdy, 1'b1);
    check_value("pslverr", err, exp_err);
  endtask

  task automatic read_check(input string name, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] exp);
    apb_access(1'b0, addr, '0, 1'b0, rdata);
    check_value(name, rdata, exp);
  endtask

  // poll status until the fifo is empty and every expected word came out
  task automatic wait_drained();
    int polls;
    logic done;
    polls = 0;
    done = 1'b0;
    while (!done && polls < DRAIN_POLLS) begin
      apb_access(1'b0, reg_status, '0, 1'b0, rdata);
      done = (exp_q.size() == 0) && !rdata[STATUS_BUSY_BIT];
      polls++;
    end
    checks++;
    assert (done) else begin
      errors++;
      $display("encoder did not drain, %0d words still expected", exp_q.size());
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, chip side, scoreboard, watchdog

  initial begin
    forever #4 clk = ~clk;
  end

  // chip ack, random stalls only in stall mode
  always @(negedge clk) begin
    ack_state = lcg_step(ack_state);
    bd_ack = stall_mode ? (ack_state[31:29] > 3'd3) : 1'b1;
  end

  // each transfer must match the oldest predicted word
  always @(posedge clk) begin
    if (arst_n && bd_valid && bd_ack) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("unexpected word 0x%h on the output channel", bd_data);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        check_value("bd_data", bd_data, exp_word);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    arst_n = 1'b0;
    in_leaf = '0;
    in_payload = '0;
    in_valid = 1'b0;
    bd_ack = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    stim_state = SEED;
    ack_state = SEED;
    stall_mode = 1'b0;
    saw_full = 1'b0;
    sent_exp = 0;
    drop_exp = 0;
    checks = 0;
    errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    apb_access(1'b1, reg_ctrl, 32'h1, 1'b0, rdata);

    // every leaf once, table order
    for (i = 0; i < N_LEAVES; i++) begin
      push_word(CODE_W'(i), PAYLOAD_W'(next_rand()));
    end
    idle_input();
    wait_drained();

    // bad codes swallowed, the valid words around them still come out
    for (i = N_LEAVES; i < 64; i++) begin
      push_word(CODE_W'(i), PAYLOAD_W'(next_rand()));
      push_word(CODE_W'(next_rand() % N_LEAVES), PAYLOAD_W'(next_rand()));
    end
    idle_input();
    wait_drained();
    read_check("reg_drop", reg_drop, drop_exp);

    // chip stalls, a few bad codes mixed in
    stall_mode = 1'b1;
    for (i = 0; i < N_STALL_WORDS; i++) begin
      push_word(CODE_W'(next_rand() % 40), PAYLOAD_W'(next_rand()));
    end
    idle_input();
    wait_drained();
    stall_mode = 1'b0;
    checks++;
    assert (saw_full) else begin
      errors++;
      $display("in_ack never fell during the stalled burst");
    end

    // disabled: the fifo fills and holds
    apb_access(1'b1, reg_ctrl, 32'h0, 1'b0, rdata);
    for (i = 0; i < FIFO_DEPTH; i++) begin
      push_word(CODE_W'(next_rand() % N_LEAVES), PAYLOAD_W'(next_rand()));
    end
    idle_input();
    repeat (8) @(negedge clk);
    check_value("in_ack", in_ack, 1'b0);
    checks++;
    assert (exp_q.size() == FIFO_DEPTH) else begin
      errors++;
      $display("words left the encoder while it was disabled");
    end
    read_check("reg_status", reg_status, 32'h2);
    apb_access(1'b1, reg_ctrl, 32'h1, 1'b0, rdata);
    wait_drained();

    // counters, clear, bus errors
    read_check("reg_sent", reg_sent, sent_exp);
    read_check("reg_drop", reg_drop, drop_exp);
    apb_access(1'b1, reg_ctrl, 32'h3, 1'b0, rdata);
    read_check("reg_sent", reg_sent, 32'h0);
    read_check("reg_drop", reg_drop, 32'h0);
    read_check("reg_ctrl", reg_ctrl, 32'h1);
    apb_access(1'b0, 8'h10, '0, 1'b1, rdata);
    apb_access(1'b1, reg_sent, 32'h5, 1'b1, rdata);
    read_check("reg_sent", reg_sent, 32'h0);

    fails = errors + DUT.u_assert.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, DUT.u_assert.fail_count);
    if (fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/bd_link_pkg.sv
src/bd_leaf_pkg.sv
src/bd_word_fifo.sv
src/bd_encoder.sv
src/bd_ctrl_regs.sv
src/bd_encoder_top.sv
bench/bd_encoder_assertions.sv
bench/bd_encoder_tb.sv

/* src/bd_ctrl_regs.sv */
`timescale 1ns/1ps

module bd_ctrl_regs
  import bd_link_pkg::*;
#(
  parameter int CNT_W = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  sent_pulse,
  input  logic                  drop_pulse,
  input  logic                  fifo_valid,
  output logic                  enable
);

  logic                  access;
  logic                  addr_hit;
  logic                  addr_ro;
  logic [APB_DATA_W-1:0] rd_word;
  logic                  ctrl_wr;
  logic                  cnt_clr;
  logic [CNT_W-1:0]      sent_cnt;
  logic [CNT_W-1:0]      drop_cnt;

  // counters stick at all ones
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // apb decode

  // no wait states
  assign pready = 1'b1;
  assign access = psel & penable;

  always_comb begin
    addr_hit = 1'b1;
    addr_ro = 1'b0;
    rd_word = '0;
    case (paddr)
      reg_ctrl: begin
        // clear bit always reads 0
        rd_word[CTRL_EN_BIT] = enable;
      end
      reg_sent: begin
        addr_ro = 1'b1;
        rd_word = APB_DATA_W'(sent_cnt);
      end
      reg_drop: begin
        addr_ro = 1'b1;
        rd_word = APB_DATA_W'(drop_cnt);
      end
      reg_status: begin
        addr_ro = 1'b1;
        rd_word[CTRL_EN_BIT] = enable;
        rd_word[STATUS_BUSY_BIT] = fifo_valid;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  assign prdata = (access & ~pwrite) ? rd_word : '0;
  // unmapped or read-only write
  assign pslverr = access & (~addr_hit | (pwrite & addr_ro));

  assign ctrl_wr = access & pwrite & (paddr == reg_ctrl);
  assign cnt_clr = ctrl_wr & pwdata[CTRL_CLR_BIT];

  //////////////////////////////////////////////////////////////////////
  // control and counters

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
      sent_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      if (ctrl_wr) begin
        enable <= pwdata[CTRL_EN_BIT];
      end
      // clear wins over a same-cycle count
      if (cnt_clr) begin
        sent_cnt <= '0;
        drop_cnt <= '0;
      end else begin
        if (sent_pulse) begin
          sent_cnt <= sat_inc(sent_cnt);
        end
        if (drop_pulse) begin
          drop_cnt <= sat_inc(drop_cnt);
        end
      end
    end
  end

endmodule

/* src/bd_encoder.sv */
`timescale 1ns/1ps

module bd_encoder
  import bd_link_pkg::*;
  import bd_leaf_pkg::*;
(
  input  logic [CODE_W-1:0]    fifo_leaf,
  input  logic [PAYLOAD_W-1:0] fifo_payload,
  input  logic                 fifo_valid,
  output logic                 fifo_pop,
  input  logic                 enable,
  output logic [BD_W-1:0]      bd_data,
  output logic                 bd_valid,
  input  logic                 bd_ack,
  output logic                 sent_pulse,
  output logic                 drop_pulse
);

  logic                   leaf_ok;
  logic [CODE_W-1:0]      leaf_idx;
  logic [ROUTE_W-1:0]     route;
  logic [ROUTE_LEN_W-1:0] route_len;
  logic [BD_W-1:0]        payload_ext;
  logic [BD_W-1:0]        shifted;
  logic                   head_live;

  //////////////////////////////////////////////////////////////////////
  // route lookup

  assign leaf_ok = (fifo_leaf < CODE_W'(N_LEAVES));
  // keep the table index in range for bad codes
  assign leaf_idx = leaf_ok ? fifo_leaf : '0;
  assign route = LEAF_ROUTE[leaf_idx];
  assign route_len = LEAF_ROUTE_LEN[leaf_idx];

  //////////////////////////////////////////////////////////////////////
  // word build

  // top payload bits fall off at 21 bits on deep leaves
  assign payload_ext = BD_W'(fifo_payload);

  // one fixed shift per tree depth
  always_comb begin
    case (route_len)
      4'd1:    shifted = payload_ext << 1;
      4'd3:    shifted = payload_ext << 3;
      4'd4:    shifted = payload_ext << 4;
      4'd6:    shifted = payload_ext << 6;
      4'd7:    shifted = payload_ext << 7;
      4'd8:    shifted = payload_ext << 8;
      default: shifted = '0;
    endcase
  end

  // route bits in the freed low bits, zero for bad codes
  assign bd_data = leaf_ok ? (shifted | BD_W'(route)) : '0;

  //////////////////////////////////////////////////////////////////////
  // handshake

  // head word may move only while enabled
  assign head_live = fifo_valid & enable;

  // good leaves wait for the chip ack
  assign bd_valid = head_live & leaf_ok;
  assign sent_pulse = bd_valid & bd_ack;

  // bad leaves are swallowed at once
  assign drop_pulse = head_live & ~leaf_ok;

  assign fifo_pop = sent_pulse | drop_pulse;

endmodule

/* src/bd_encoder_top.sv */
`timescale 1ns/1ps

module bd_encoder_top
  import bd_link_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  parameter int CNT_W = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  // host words
  input  logic [CODE_W-1:0]     in_leaf,
  input  logic [PAYLOAD_W-1:0]  in_payload,
  input  logic                  in_valid,
  output logic                  in_ack,
  // chip words
  output logic [BD_W-1:0]       bd_data,
  output logic                  bd_valid,
  input  logic                  bd_ack,
  // config
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  // fifo head to encoder
  logic [CODE_W-1:0]    fifo_leaf;
  logic [PAYLOAD_W-1:0] fifo_payload;
  logic                 fifo_valid;
  logic                 fifo_pop;
  // encoder to and from registers
  logic                 enable;
  logic                 sent_pulse;
  logic                 drop_pulse;

  bd_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_leaf      (in_leaf),
    .in_payload   (in_payload),
    .in_valid     (in_valid),
    .in_ack       (in_ack),
    .fifo_leaf    (fifo_leaf),
    .fifo_payload (fifo_payload),
    .fifo_valid   (fifo_valid),
    .fifo_pop     (fifo_pop)
  );

  bd_encoder u_enc (
    .fifo_leaf    (fifo_leaf),
    .fifo_payload (fifo_payload),
    .fifo_valid   (fifo_valid),
    .fifo_pop     (fifo_pop),
    .enable       (enable),
    .bd_data      (bd_data),
    .bd_valid     (bd_valid),
    .bd_ack       (bd_ack),
    .sent_pulse   (sent_pulse),
    .drop_pulse   (drop_pulse)
  );

  bd_ctrl_regs #(
    .CNT_W (CNT_W)
  ) u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .sent_pulse (sent_pulse),
    .drop_pulse (drop_pulse),
    .fifo_valid (fifo_valid),
    .enable     (enable)
  );

endmodule

/* src/bd_leaf_pkg.sv */
package bd_leaf_pkg;
  import bd_link_pkg::*;

  // valid leaves in the downstream tree
  // any code at or above this is invalid
  localparam int N_LEAVES = 34;
  // longest route in the tree, in bits
  localparam int ROUTE_W = 8;
  localparam int ROUTE_LEN_W = 4;
  localparam int LEAF_WIDTH_W = 5;

  //////////////////////////////////////////////////////////////////////
  // leaf codes, in routing table order

  typedef enum logic [CODE_W-1:0] {
    adc, dac0, dac10, dac11, dac12,
    dac1, dac2, dac3, dac4, dac5, dac6, dac7, dac8, dac9,
    delay0, delay1, delay2, delay3, delay4, delay5, delay6,
    init_fifo_dct, init_fifo_ht,
    neuron_config, neuron_dump_toggle, neuron_inject,
    prog_ammm, prog_pat, prog_tat0, prog_tat1,
    ri,
    toggle_post_fifo0, toggle_post_fifo1, toggle_pre_fifo
  } leaf_e;

  //////////////////////////////////////////////////////////////////////
  // route tables, index 0 is adc

  // route bits, lsb is the first hop taken at the tree root
  // upper bits beyond the route length are zero
  localparam logic [0:N_LEAVES-1][ROUTE_W-1:0] LEAF_ROUTE = '{
    8'h05, 8'h0d, 8'h5d, 8'h3d, 8'h7d,                      // adc, dac0, dac10..12
    8'h8d, 8'h4d, 8'hcd, 8'h2d, 8'had, 8'h6d, 8'hed, 8'h1d, // dac1..dac8
    8'h9d,                                                  // dac9
    8'h01, 8'h21, 8'h71, 8'hf1, 8'h09, 8'h19, 8'h59,        // delay0..6
    8'h31, 8'h11,                                           // fifo init
    8'h03, 8'h0f, 8'h07,                                    // neuron array
    8'h39, 8'h29, 8'h41, 8'h61,                             // prog ports
    8'h00,                                                  // ri
    8'h51, 8'hd1, 8'h91                                     // fifo toggles
  };

  // depth of each leaf in the tree
  // only 1, 3, 4, 6, 7 and 8 occur
  localparam logic [0:N_LEAVES-1][ROUTE_LEN_W-1:0] LEAF_ROUTE_LEN = '{
    4'd4, 4'd8, 4'd7, 4'd7, 4'd7,
    4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8,
    4'd7, 4'd7, 4'd8, 4'd8, 4'd6, 4'd7, 4'd7,
    4'd7, 4'd8,
    4'd3, 4'd4, 4'd4,
    4'd6, 4'd6, 4'd7, 4'd7,
    4'd1,
    4'd8, 4'd8, 4'd8
  };

  // payload bits carried per word (one chunk of wide leaves)
  localparam logic [0:N_LEAVES-1][LEAF_WIDTH_W-1:0] LEAF_WIDTH = '{
    5'd3, 5'd11, 5'd11, 5'd11, 5'd11,
    5'd11, 5'd11, 5'd11, 5'd11, 5'd11, 5'd11, 5'd11, 5'd11, 5'd11,
    5'd8, 5'd8, 5'd8, 5'd8, 5'd8, 5'd8, 5'd8,
    5'd11, 5'd1,
    5'd18, 5'd2, 5'd11,
    5'd11, 5'd7, 5'd8, 5'd8,
    5'd20,
    5'd2, 5'd2, 5'd2
  };

endpackage

/* src/bd_link_pkg.sv */
package bd_link_pkg;

  // host word fields
  localparam int CODE_W = 6;
  localparam int PAYLOAD_W = 20;
  // chip word, payload above route
  localparam int BD_W = 21;

  // apb config port
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // register map, byte offsets
  typedef enum logic [APB_ADDR_W-1:0] {
    reg_ctrl   = 8'h00,
    reg_sent   = 8'h04,
    reg_drop   = 8'h08,
    reg_status = 8'h0c
  } reg_addr_e;

  // bit fields of reg_ctrl and reg_status
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_CLR_BIT = 1;
  localparam int STATUS_BUSY_BIT = 1;

endpackage

/* src/bd_word_fifo.sv */
`timescale 1ns/1ps

module bd_word_fifo
  import bd_link_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [CODE_W-1:0]    in_leaf,
  input  logic [PAYLOAD_W-1:0] in_payload,
  input  logic                 in_valid,
  output logic                 in_ack,
  output logic [CODE_W-1:0]    fifo_leaf,
  output logic [PAYLOAD_W-1:0] fifo_payload,
  output logic                 fifo_valid,
  input  logic                 fifo_pop
);

  // depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CODE_W-1:0]    mem_leaf    [FIFO_DEPTH];
  logic [PAYLOAD_W-1:0] mem_payload [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [COUNT_W-1:0]   count;
  logic                 push;
  logic                 pop;

  // host side handshake
  assign in_ack = (count != COUNT_W'(FIFO_DEPTH));
  assign push = in_valid & in_ack;

  // head word straight from storage
  assign fifo_valid = (count != '0);
  assign fifo_leaf = mem_leaf[rd_ptr];
  assign fifo_payload = mem_payload[rd_ptr];
  // ignore pops on empty
  assign pop = fifo_pop & fifo_valid;

  // pointers and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_leaf[wr_ptr] <= in_leaf;
      mem_payload[wr_ptr] <= in_payload;
    end
  end

endmodule
